// File: hw/had_common_regs.sv
/*
 * HAD common registers
 * Reset status (RSR), identification (ID) and debug mask status (DMS)
 * registers, core debug mask outputs and the AND-OR read multiplexer
 * that also carries the DBGFIFO2 head
 */

`timescale 1ns/100ps

module had_common_regs (
  input  logic                forever_cpuclk,
  input  logic                core0_rst_b,
  input  logic                core1_rst_b,
  had_sel_if.rd               sel,
  input  had_pkg::core_mask_t sysio_had_dbg_mask,
  input  had_pkg::had_word_t  dbgfifo2_data,
  output had_pkg::had_word_t  common_regs_data,
  output logic                core0_had_dbg_mask,
  output logic                core1_had_dbg_mask
);

  //==========================================================================
  // RSR
  //==========================================================================
  // Per-core reset flags
  logic core_rst0;
  logic core_rst1;

  had_pkg::core_mask_t core_rst;
  had_pkg::had_reg32_t rsr_data;

  // Set while core 0 is in reset
  // Clears on the first clock after release
  always_ff @(posedge forever_cpuclk or negedge core0_rst_b)
  begin
    if (!core0_rst_b)
      core_rst0 <= 1'b1;
    else
      core_rst0 <= 1'b0;
  end

  // Same for core 1 on its own reset
  always_ff @(posedge forever_cpuclk or negedge core1_rst_b)
  begin
    if (!core1_rst_b)
      core_rst1 <= 1'b1;
    else
      core_rst1 <= 1'b0;
  end

  // Absent slots read as held in reset
  assign core_rst = {2'b00, core_rst1, core_rst0} | had_pkg::ABSENT_CORES;
  assign rsr_data = {28'b0, core_rst};

  //==========================================================================
  // ID and DMS
  //==========================================================================
  had_pkg::had_reg32_t id_data;
  had_pkg::had_reg32_t dms_data;

  // Fixed identification word
  assign id_data  = had_pkg::HAD_ID_VALUE;
  // System debug mask as seen by the debugger
  assign dms_data = {28'b0, sysio_had_dbg_mask};

  // Only cores 0 and 1 exist
  assign core0_had_dbg_mask = sysio_had_dbg_mask[0];
  assign core1_had_dbg_mask = sysio_had_dbg_mask[1];

  //==========================================================================
  // Read multiplexer
  //==========================================================================
  // Each source gated by its own select
  had_pkg::had_word_t fifo_term;
  had_pkg::had_word_t rsr_term;
  had_pkg::had_word_t id_term;
  had_pkg::had_word_t dms_term;

  assign fifo_term = {64{sel.dbgfifo2_sel}} & dbgfifo2_data;
  assign rsr_term  = {64{sel.rsr_sel}}      & {32'b0, rsr_data};
  assign id_term   = {64{sel.id_sel}}       & {32'b0, id_data};
  assign dms_term  = {64{sel.dms_sel}}      & {32'b0, dms_data};

  // No select reads as zero
  assign common_regs_data = fifo_term | rsr_term | id_term | dms_term;

endmodule

// File: hw/had_dbg_fifo.sv
/*
 * HAD second debug FIFO
 * Four-deep 64-bit circular buffer filled by the cores and popped
 * by debugger reads of DBGFIFO2
 * The head reads zero when empty
 */

`timescale 1ns/100ps

module had_dbg_fifo (
  input  logic              forever_cpuclk,
  input  logic              core0_rst_b,
  input  logic              fifo_push,
  input  had_pkg::had_word_t fifo_wdata,
  input  logic              fifo_pop,
  output had_pkg::had_word_t head_data,
  output logic              fifo_full,
  output logic              fifo_empty
);

  //==========================================================================
  // Storage and pointers
  //==========================================================================
  // Entry storage
  had_pkg::had_word_t mem [had_pkg::FIFO_DEPTH];

  had_pkg::fifo_ptr_t wr_ptr;
  had_pkg::fifo_ptr_t rd_ptr;
  had_pkg::fifo_cnt_t fifo_cnt;

  // Qualified enables
  logic wr_en;
  logic rd_en;

  // Push into a full FIFO is lost
  assign wr_en = fifo_push && !fifo_full;
  // Pop of an empty FIFO does nothing
  assign rd_en = fifo_pop && !fifo_empty;

  //==========================================================================
  // Write side
  //==========================================================================
  always_ff @(posedge forever_cpuclk)
  begin
    if (wr_en)
      mem[wr_ptr] <= fifo_wdata;
  end

  // Pointer width matches the depth, so the last entry wraps to zero
  always_ff @(posedge forever_cpuclk or negedge core0_rst_b)
  begin
    if (!core0_rst_b)
      wr_ptr <= '0;
    else if (wr_en)
      wr_ptr <= wr_ptr + 1'b1;
  end

  //==========================================================================
  // Read side
  //==========================================================================
  always_ff @(posedge forever_cpuclk or negedge core0_rst_b)
  begin
    if (!core0_rst_b)
      rd_ptr <= '0;
    else if (rd_en)
      rd_ptr <= rd_ptr + 1'b1;
  end

  // Occupancy count
  // Push and pop together leave it unchanged
  always_ff @(posedge forever_cpuclk or negedge core0_rst_b)
  begin
    if (!core0_rst_b)
      fifo_cnt <= '0;
    else if (wr_en && !rd_en)
      fifo_cnt <= fifo_cnt + 1'b1;
    else if (rd_en && !wr_en)
      fifo_cnt <= fifo_cnt - 1'b1;
  end

  // Status flags
  assign fifo_empty = (fifo_cnt == '0);
  assign fifo_full  = (fifo_cnt == had_pkg::fifo_cnt_t'(had_pkg::FIFO_DEPTH));

  // Oldest word or zero when nothing is held
  assign head_data = fifo_empty ? '0 : mem[rd_ptr];

  // Capture stage must only pop a FIFO that holds data
  a_no_pop_empty : assert property (
    @(posedge forever_cpuclk) disable iff (!core0_rst_b)
    fifo_pop |-> !fifo_empty
  );

endmodule

// File: hw/had_dr_capture.sv
/*
 * HAD data register capture
 * Latches the multiplexed register word on the capture strobe, flags
 * it valid for one cycle and pops DBGFIFO2 on a read of it
 */

`timescale 1ns/100ps

module had_dr_capture (
  input  logic               forever_cpuclk,
  input  logic               core0_rst_b,
  input  logic               dr_capture,
  had_sel_if.rd              sel,
  input  had_pkg::had_word_t common_regs_data,
  input  logic               fifo_empty,
  output logic               fifo_pop,
  output had_pkg::had_word_t dr_data,
  output logic               dr_valid
);

  //==========================================================================
  // FIFO pop
  //==========================================================================
  // Same cycle as the capture, so the FIFO advances on the capture edge
  // Empty FIFO reads zero and is left alone
  assign fifo_pop = dr_capture && sel.dbgfifo2_sel && !fifo_empty;

  //==========================================================================
  // Data register
  //==========================================================================
  // Zero until the first capture
  always_ff @(posedge forever_cpuclk or negedge core0_rst_b)
  begin
    if (!core0_rst_b)
      dr_data <= '0;
    else if (dr_capture)
      dr_data <= common_regs_data;
  end

  // One-cycle valid behind each capture
  always_ff @(posedge forever_cpuclk or negedge core0_rst_b)
  begin
    if (!core0_rst_b)
      dr_valid <= 1'b0;
    else
      dr_valid <= dr_capture;
  end

  // Valid two cycles running only for back-to-back captures
  a_valid_one_shot : assert property (
    @(posedge forever_cpuclk) disable iff (!core0_rst_b)
    (dr_valid && $past(dr_valid)) |-> ($past(dr_capture) && $past(dr_capture, 2))
  );

endmodule

// File: hw/had_ir_decode.sv
/*
 * HAD instruction register
 * Loads an instruction code on the update strobe and holds it as
 * registered one-hot register selects until the next update
 */

`timescale 1ns/100ps

module had_ir_decode (
  input  logic             forever_cpuclk,
  input  logic             core0_rst_b,
  input  logic             ir_update,
  input  had_pkg::ir_code_t ir_code,
  had_sel_if.dec           sel
);

  //==========================================================================
  // Code decode
  //==========================================================================
  // Next selects from the code on the bus
  logic id_sel_d;
  logic rsr_sel_d;
  logic dms_sel_d;
  logic dbgfifo2_sel_d;

  // Held selects, stand in for the loaded code
  logic id_sel_q;
  logic rsr_sel_q;
  logic dms_sel_q;
  logic dbgfifo2_sel_q;

  // Exact code match, anything else gives no select
  assign id_sel_d       = (ir_code == had_pkg::IR_ID);
  assign rsr_sel_d      = (ir_code == had_pkg::IR_RSR);
  assign dms_sel_d      = (ir_code == had_pkg::IR_DMS);
  assign dbgfifo2_sel_d = (ir_code == had_pkg::IR_DBGFIFO2);

  //==========================================================================
  // Select registers
  //==========================================================================
  // Reset leaves no register selected
  always_ff @(posedge forever_cpuclk or negedge core0_rst_b)
  begin
    if (!core0_rst_b)
    begin
      id_sel_q       <= 1'b0;
      rsr_sel_q      <= 1'b0;
      dms_sel_q      <= 1'b0;
      dbgfifo2_sel_q <= 1'b0;
    end
    else if (ir_update)
    begin
      id_sel_q       <= id_sel_d;
      rsr_sel_q      <= rsr_sel_d;
      dms_sel_q      <= dms_sel_d;
      dbgfifo2_sel_q <= dbgfifo2_sel_d;
    end
  end

  // Onto the select bundle
  assign sel.id_sel       = id_sel_q;
  assign sel.rsr_sel      = rsr_sel_q;
  assign sel.dms_sel      = dms_sel_q;
  assign sel.dbgfifo2_sel = dbgfifo2_sel_q;

  // Mux relies on at most one select
  a_sel_onehot0 : assert property (
    @(posedge forever_cpuclk) disable iff (!core0_rst_b)
    $onehot0({sel.id_sel, sel.rsr_sel, sel.dms_sel, sel.dbgfifo2_sel})
  );

endmodule

// File: hw/had_pkg.sv
/*
 * HAD common register package
 * Shared vector types, instruction codes, the fixed ID word and the
 * debug FIFO sizing used by the two-core debug register block
 */

package had_pkg;

  //==========================================================================
  // Vector types
  //==========================================================================
  // Debugger read word
  typedef logic [63:0] had_word_t;
  // RSR, ID and DMS register value
  typedef logic [31:0] had_reg32_t;
  // Instruction register code
  typedef logic [7:0]  ir_code_t;
  // One bit per core slot, slot 0 in bit 0
  typedef logic [3:0]  core_mask_t;
  // FIFO occupancy, 0 up to FIFO_DEPTH
  typedef logic [2:0]  fifo_cnt_t;

  //==========================================================================
  // Debug FIFO sizing
  //==========================================================================
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // Read and write pointer into the FIFO storage
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

  //==========================================================================
  // Instruction codes
  //==========================================================================
  // Any other code selects no register and reads as zero
  localparam ir_code_t IR_ID       = 8'h02;
  localparam ir_code_t IR_RSR      = 8'h0a;
  localparam ir_code_t IR_DMS      = 8'h11;
  localparam ir_code_t IR_DBGFIFO2 = 8'h14;

  //==========================================================================
  // Identification register fields
  //==========================================================================
  // CPU instruction architecture
  localparam logic [1:0] ID_ARCH       = 2'b10;
  // RSR implemented
  localparam logic       ID_HAS_RSR    = 1'b1;
  // HACR is 16 bits wide
  localparam logic       ID_HACR_16    = 1'b1;
  // Second register bank, not built
  localparam logic       ID_BANK1      = 1'b0;
  // Debug data channel present
  localparam logic       ID_DDC        = 1'b1;
  localparam logic [3:0] ID_BKPT_NUM   = 4'd2;
  localparam logic [3:0] ID_REVISION   = 4'hb;
  localparam logic [3:0] ID_VERSION    = 4'h4;
  localparam logic [3:0] ID_ID_VERSION = 4'h3;

  // Assembled ID word, evaluates to 32'h080d2b43
  localparam had_reg32_t HAD_ID_VALUE = {4'b0000, ID_ARCH, 6'b000000, ID_HAS_RSR,
                                         ID_HACR_16, ID_BANK1, ID_DDC, ID_BKPT_NUM,
                                         ID_REVISION, ID_VERSION, ID_ID_VERSION};

  // Core slots 2 and 3 are not built and always read as held in reset
  localparam core_mask_t ABSENT_CORES = 4'b1100;

endpackage

// File: hw/had_regs_top.sv
/*
 * HAD common register block top level
 * Instruction decoder, second debug FIFO, common registers and the
 * data register capture stage, joined by a select bundle
 */

`timescale 1ns/100ps

module had_regs_top (
  input  logic                forever_cpuclk,
  input  logic                core0_rst_b,
  input  logic                core1_rst_b,
  // Debugger side
  input  logic                ir_update,
  input  had_pkg::ir_code_t   ir_code,
  input  logic                dr_capture,
  output had_pkg::had_word_t  dr_data,
  output logic                dr_valid,
  // Core side
  input  logic                fifo_push,
  input  had_pkg::had_word_t  fifo_wdata,
  output logic                fifo_full,
  output logic                fifo_empty,
  // System debug mask
  input  had_pkg::core_mask_t sysio_had_dbg_mask,
  output logic                core0_had_dbg_mask,
  output logic                core1_had_dbg_mask
);

  //==========================================================================
  // Internal paths
  //==========================================================================
  // FIFO head into the mux
  had_pkg::had_word_t head_data;
  // Mux output into the data register
  had_pkg::had_word_t common_regs_data;
  // Pop request back to the FIFO
  logic               fifo_pop;

  // Decoded selects
  had_sel_if sel_if ();

  //==========================================================================
  // Blocks
  //==========================================================================
  had_ir_decode u_ir_decode (
    .forever_cpuclk (forever_cpuclk),
    .core0_rst_b    (core0_rst_b),
    .ir_update      (ir_update),
    .ir_code        (ir_code),
    .sel            (sel_if.dec)
  );

  had_dbg_fifo u_dbg_fifo (
    .forever_cpuclk (forever_cpuclk),
    .core0_rst_b    (core0_rst_b),
    .fifo_push      (fifo_push),
    .fifo_wdata     (fifo_wdata),
    .fifo_pop       (fifo_pop),
    .head_data      (head_data),
    .fifo_full      (fifo_full),
    .fifo_empty     (fifo_empty)
  );

  had_common_regs u_common_regs (
    .forever_cpuclk     (forever_cpuclk),
    .core0_rst_b        (core0_rst_b),
    .core1_rst_b        (core1_rst_b),
    .sel                (sel_if.rd),
    .sysio_had_dbg_mask (sysio_had_dbg_mask),
    .dbgfifo2_data      (head_data),
    .common_regs_data   (common_regs_data),
    .core0_had_dbg_mask (core0_had_dbg_mask),
    .core1_had_dbg_mask (core1_had_dbg_mask)
  );

  had_dr_capture u_dr_capture (
    .forever_cpuclk   (forever_cpuclk),
    .core0_rst_b      (core0_rst_b),
    .dr_capture       (dr_capture),
    .sel              (sel_if.rd),
    .common_regs_data (common_regs_data),
    .fifo_empty       (fifo_empty),
    .fifo_pop         (fifo_pop),
    .dr_data          (dr_data),
    .dr_valid         (dr_valid)
  );

endmodule

// File: hw/had_sel_if.sv
/*
 * HAD register select bundle
 * Decoded one-hot register selects from the instruction register
 * to the read multiplexer and the capture stage
 */

`timescale 1ns/100ps

interface had_sel_if;

  // Identification register
  logic id_sel;
  // Reset status register
  logic rsr_sel;
  // Debug mask status register
  logic dms_sel;
  // Second debug FIFO, a read pops it
  logic dbgfifo2_sel;

  // Instruction decoder drives every select
  modport dec (
    output id_sel,
    output rsr_sel,
    output dms_sel,
    output dbgfifo2_sel
  );

  // Read side, mux and capture
  modport rd (
    input id_sel,
    input rsr_sel,
    input dms_sel,
    input dbgfifo2_sel
  );

endinterface

// File: sources.f
hw/had_pkg.sv
hw/had_sel_if.sv
hw/had_ir_decode.sv
hw/had_dbg_fifo.sv
hw/had_common_regs.sv
hw/had_dr_capture.sv
hw/had_regs_top.sv
tests/tb_clk_gen.sv
tests/tb_had_regs.sv

// File: tests/tb_clk_gen.sv
/*
 * Testbench clock and reset
 * 8 ns clock and a core 0 reset held low for the first two cycles
 */

`timescale 1ns/100ps

module tb_clk_gen (
  output logic forever_cpuclk,
  output logic core0_rst_b
);

  localparam int HALF_NS = 4;

  initial
  begin
    forever_cpuclk = 1'b0;
    forever
      #(HALF_NS) forever_cpuclk = ~forever_cpuclk;
  end

  // Reset released on the second rising edge
  initial
  begin
    core0_rst_b = 1'b0;
    repeat (2) @(posedge forever_cpuclk);
    core0_rst_b <= 1'b1;
  end

endmodule

// File: tests/tb_had_regs.sv
/*
 * Debug register block testbench
 * Directed tests of ID, RSR, DMS, the debug FIFO and capture timing,
 * with a queue model of the FIFO fed by an LCG
 */

`timescale 1ns/100ps

module tb_had_regs;

  // Codes and ID word as the register map defines them
  localparam logic [7:0]  CODE_ID       = 8'h02;
  localparam logic [7:0]  CODE_RSR      = 8'h0a;
  localparam logic [7:0]  CODE_DMS      = 8'h11;
  localparam logic [7:0]  CODE_DBGFIFO2 = 8'h14;
  localparam logic [63:0] ID_WORD       = 64'h0000_0000_080d_2b43;
  // 6 tests at 200 cycles each, plus reset
  localparam int WDOG_CYCLES = 6 * 200 + 2;

  logic                forever_cpuclk;
  logic                core0_rst_b;
  logic                core1_rst_b;
  logic                ir_update;
  had_pkg::ir_code_t   ir_code;
  logic                dr_capture;
  had_pkg::had_word_t  dr_data;
  logic                dr_valid;
  logic                fifo_push;
  had_pkg::had_word_t  fifo_wdata;
  logic                fifo_full;
  logic                fifo_empty;
  had_pkg::core_mask_t sysio_had_dbg_mask;
  logic                core0_had_dbg_mask;
  logic                core1_had_dbg_mask;

  int                 error_count = 0;
  int                 tests_passed = 0;
  int                 tests_failed = 0;
  logic [31:0]        lcg_state;
  // Expected FIFO contents, oldest first
  had_pkg::had_word_t fifo_model [$];

  tb_clk_gen u_clk_gen (.forever_cpuclk(forever_cpuclk), .core0_rst_b(core0_rst_b));

  had_regs_top DUT (.*);

  //==========================================================================
  // Helpers
  //==========================================================================
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Two LCG steps per 64-bit word
  function automatic had_pkg::had_word_t next_rand_word();
    logic [31:0] hi;
    hi = lcg_step(lcg_state);
    lcg_state = lcg_step(hi);
    return {hi, lcg_state};
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] act,
                                 input logic [63:0] exp);
    $display("** Error at %0t: %s = 'h%0h, expected 'h%0h", $realtime, name, act, exp);
    error_count++;
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (error_count == err_before)
    begin
      tests_passed++;
      $display("PASS  %s", name);
    end
    else
    begin
      tests_failed++;
      $display("FAIL  %s, %0d errors", name, error_count - err_before);
    end
  endtask

  // Load code, capture, wait for dr_valid, sample at the falling edge
  task automatic read_reg(input logic [7:0] code, output had_pkg::had_word_t data);
    int waited;
    @(posedge forever_cpuclk);
    ir_code   <= code;
    ir_update <= 1'b1;
    @(posedge forever_cpuclk);
    ir_update  <= 1'b0;
    dr_capture <= 1'b1;
    @(posedge forever_cpuclk);
    dr_capture <= 1'b0;
    waited = 0;
    @(negedge forever_cpuclk);
    while (!dr_valid && waited < 16)
    begin
      @(negedge forever_cpuclk);
      waited++;
    end
    if (!dr_valid)
    begin
      $display("dr_valid never rose after capture of code 'h%0h", code);
      error_count++;
    end
    data = dr_data;
  endtask

  // One push, the model drops it when four words are held
  task automatic push_word(input had_pkg::had_word_t word);
    @(posedge forever_cpuclk);
    fifo_push  <= 1'b1;
    fifo_wdata <= word;
    @(posedge forever_cpuclk);
    fifo_push <= 1'b0;
    if (fifo_model.size() < 4)
      fifo_model.push_back(word);
    @(negedge forever_cpuclk);
  endtask

  // DBGFIFO2 read against the model, zero when empty
  task automatic read_fifo_check();
    had_pkg::had_word_t got;
    had_pkg::had_word_t exp;
    exp = '0;
    if (fifo_model.size() > 0)
      exp = fifo_model.pop_front();
    read_reg(CODE_DBGFIFO2, got);
    if (got !== exp)
      report_mismatch("dr_data", got, exp);
  endtask

  //==========================================================================
  // Tests
  //==========================================================================
  task automatic test_capture_timing();
    int   err0;
    logic [9:0] pattern;
    logic last_drive;
    err0 = error_count;
    // Reset state, then a capture with no code loaded
    @(negedge forever_cpuclk);
    if (dr_valid !== 1'b0)
      report_mismatch("dr_valid", dr_valid, 0);
    if (dr_data !== '0)
      report_mismatch("dr_data", dr_data, 0);
    @(posedge forever_cpuclk);
    dr_capture <= 1'b1;
    @(posedge forever_cpuclk);
    dr_capture <= 1'b0;
    @(negedge forever_cpuclk);
    if (dr_valid !== 1'b1)
      report_mismatch("dr_valid", dr_valid, 1);
    if (dr_data !== '0)
      report_mismatch("dr_data", dr_data, 0);
    @(posedge forever_cpuclk);
    ir_code   <= CODE_ID;
    ir_update <= 1'b1;
    @(posedge forever_cpuclk);
    ir_update <= 1'b0;
    // Valid each cycle must follow the capture one edge earlier
    pattern    = 10'b00_0010_0101;
    last_drive = 1'b0;
    for (int i = 0; i < 12; i++)
    begin
      @(posedge forever_cpuclk);
      dr_capture <= (i < 10) ? pattern[i] : 1'b0;
      @(negedge forever_cpuclk);
      if (dr_valid !== last_drive)
        report_mismatch("dr_valid", dr_valid, last_drive);
      if (last_drive && dr_data !== ID_WORD)
        report_mismatch("dr_data", dr_data, ID_WORD);
      last_drive = (i < 10) ? pattern[i] : 1'b0;
    end
    finish_test("capture timing", err0);
  endtask

  task automatic test_id_read();
    int err0;
    had_pkg::had_word_t got;
    err0 = error_count;
    read_reg(CODE_ID, got);
    if (got !== ID_WORD)
      report_mismatch("dr_data", got, ID_WORD);
    // Unknown code selects nothing
    read_reg(8'h55, got);
    if (got !== '0)
      report_mismatch("dr_data", got, 0);
    finish_test("ID read", err0);
  endtask

  task automatic test_rsr();
    int err0;
    had_pkg::had_word_t got;
    err0 = error_count;
    read_reg(CODE_RSR, got);
    if (got !== 64'hc)
      report_mismatch("dr_data", got, 64'hc);
    @(posedge forever_cpuclk);
    core1_rst_b <= 1'b0;
    read_reg(CODE_RSR, got);
    if (got !== 64'he)
      report_mismatch("dr_data", got, 64'he);
    @(posedge forever_cpuclk);
    core1_rst_b <= 1'b1;
    read_reg(CODE_RSR, got);
    if (got !== 64'hc)
      report_mismatch("dr_data", got, 64'hc);
    finish_test("RSR tracking", err0);
  endtask

  task automatic test_dms();
    int err0;
    had_pkg::had_word_t got;
    logic [3:0] masks [5] = '{4'b0101, 4'b1010, 4'b1111, 4'b0011, 4'b0000};
    err0 = error_count;
    foreach (masks[k])
    begin
      @(posedge forever_cpuclk);
      sysio_had_dbg_mask <= masks[k];
      read_reg(CODE_DMS, got);
      if (got !== {60'b0, masks[k]})
        report_mismatch("dr_data", got, {60'b0, masks[k]});
    end
    finish_test("DMS and core masks", err0);
  endtask

  task automatic test_fifo_order();
    int err0;
    err0 = error_count;
    repeat (3) push_word(next_rand_word());
    // Fourth read finds the FIFO empty
    repeat (4) read_fifo_check();
    if (fifo_empty !== 1'b1)
      report_mismatch("fifo_empty", fifo_empty, 1);
    finish_test("FIFO order", err0);
  endtask

  task automatic test_fifo_overflow();
    int err0;
    err0 = error_count;
    for (int k = 0; k < 5; k++)
    begin
      push_word(next_rand_word());
      if (fifo_full !== (k >= 3))
        report_mismatch("fifo_full", fifo_full, (k >= 3));
    end
    repeat (4) read_fifo_check();
    if (fifo_empty !== 1'b1)
      report_mismatch("fifo_empty", fifo_empty, 1);
    finish_test("FIFO overflow", err0);
  endtask

  //==========================================================================
  // Run control
  //==========================================================================
  // Core mask outputs follow the system mask at all times
  always @(negedge forever_cpuclk)
  begin
    if (core0_had_dbg_mask !== sysio_had_dbg_mask[0])
      report_mismatch("core0_had_dbg_mask", core0_had_dbg_mask, sysio_had_dbg_mask[0]);
    if (core1_had_dbg_mask !== sysio_had_dbg_mask[1])
      report_mismatch("core1_had_dbg_mask", core1_had_dbg_mask, sysio_had_dbg_mask[1]);
  end

  initial
  begin
    #(WDOG_CYCLES * 8);
    $display("Watchdog expired after %0d cycles, tests did not finish", WDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial
  begin
    $timeformat(-9, 1, " ns", 0);
    core1_rst_b        = 1'b0;
    ir_update          = 1'b0;
    ir_code            = '0;
    dr_capture         = 1'b0;
    fifo_push          = 1'b0;
    fifo_wdata         = '0;
    sysio_had_dbg_mask = '0;
    lcg_state          = 32'hda308741;
    wait (core0_rst_b === 1'b1);
    @(posedge forever_cpuclk);
    core1_rst_b <= 1'b1;
    test_capture_timing();
    test_id_read();
    test_rsr();
    test_dms();
    test_fifo_order();
    test_fifo_overflow();
    $display("Tests: %0d passed, %0d failed, %0d errors",
             tests_passed, tests_failed, error_count);
    if (error_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule
